// File: Makefile
# Verilator flow for the pulse-width line receiver

VERILATOR  ?= verilator
TOP        ?= pwl_rx_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --timing --assert
SIM_FLAGS  ?= $(LINT_FLAGS) -Wno-fatal
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_TEXT  ?= ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/pwl_rx_props.sv
`timescale 1ns/1ps
`default_nettype none

module pwl_rx_props (
    input logic                      sample_clk,
    input logic                      arst_n,
    input logic                      operation,
    input pwl_line_pkg::cell_state_t state,
    input logic                      bit_valid,
    input logic                      frame_end,
    input logic                      tx_handoff
);

    import pwl_line_pkg::*;

    int fail_count = 0;

    // **************************************************
    // Decoder properties
    // **************************************************

    // Final bit always rides with the frame end
    frame_end_has_bit: assert property (@(posedge sample_clk) disable iff (!arst_n)
        frame_end |-> bit_valid)
        else begin
            fail_count++;
            $error("frame_end without bit_valid");
        end

    // Handoff only moves together with a frame end
    handoff_on_frame_end: assert property (@(posedge sample_clk) disable iff (!arst_n)
        (tx_handoff != $past(tx_handoff)) |-> frame_end)
        else begin
            fail_count++;
            $error("tx_handoff changed outside a frame end");
        end

    // Transmitter owns the line, decoder parked and silent
    quiet_while_tx: assert property (@(posedge sample_clk) disable iff (!arst_n)
        operation |=> (!bit_valid && !frame_end && (state == AWAIT_FIRST_FALL)))
        else begin
            fail_count++;
            $error("Decoder active while operation was high");
        end

endmodule

bind bit_cell_decoder pwl_rx_props pwl_rx_props_inst (
    .sample_clk (sample_clk),
    .arst_n     (arst_n),
    .operation  (operation),
    .state      (state),
    .bit_valid  (bit_valid),
    .frame_end  (frame_end),
    .tx_handoff (tx_handoff)
);

`default_nettype wire

// File: dv/pwl_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pwl_rx_tb;

    import pwl_line_pkg::*;
    import pwl_frame_pkg::*;

    localparam int SHORT_W     = 3;
    localparam int LONG_W      = 9;
    localparam int IDLE_W      = 30;
    localparam int RAND_FRAMES = 20;
    localparam int MAX_BYTES   = 6;
    localparam int DRAIN_LIMIT = 64;

    logic        sample_clk;
    logic        arst_n;
    logic        operation;
    logic        line;
    logic        byte_valid;
    byte_t       byte_data;
    logic        frame_done;
    byte_count_t frame_bytes;
    logic        frame_partial;
    logic        tx_handoff;

    // Low and high widths, one pair per bit cell
    int          cells[$];
    byte_t       exp_bytes[$];
    byte_count_t exp_counts[$];
    logic        exp_partials[$];

    byte_t       frame_data[0:MAX_BYTES-1];
    int          rand_len[0:RAND_FRAMES-1];
    byte_t       rand_data[0:RAND_FRAMES*MAX_BYTES-1];
    int          tie_widths[0:15] = '{5, 5, 6, 5, 5, 5, 6, 5, 5, 5, 6, 5, 6, 5, 3, 30};

    int          seed;
    int          error_count;
    int          bytes_seen;
    int          frames_seen;
    int          frames_sent;
    int          cycle_count;
    int          cycle_limit;

    pwl_rx_top pwl_rx_top_inst (
        .sample_clk    (sample_clk),
        .arst_n        (arst_n),
        .operation     (operation),
        .line          (line),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .frame_done    (frame_done),
        .frame_bytes   (frame_bytes),
        .frame_partial (frame_partial),
        .tx_handoff    (tx_handoff)
    );

    initial sample_clk = 1'b0;
    always #50 sample_clk = ~sample_clk;

    // **************************************************
    // Reference model
    // **************************************************

    // Long low gives 0, tie or long high gives 1, idle high ends the frame with a 1
    function automatic void decode_cells(input int widths[$]);
        byte_t cur;
        int    pos;
        int    count;
        int    low_w;
        int    high_w;
        logic  b;
        cur   = '0;
        pos   = 0;
        count = 0;
        for (int i = 0; i + 1 < widths.size(); i += 2) begin
            low_w  = widths[i];
            high_w = widths[i+1];
            if (high_w >= int'(IDLE_CYCLES)) begin
                b = 1'b1;
            end else begin
                b = (low_w > high_w) ? 1'b0 : 1'b1;
            end
            cur[pos] = b;
            pos++;
            if (pos == BITS_PER_BYTE) begin
                exp_bytes.push_back(cur);
                if (count < int'(MAX_FRAME_BYTES)) begin
                    count++;
                end
                pos = 0;
                cur = '0;
            end
            if (high_w >= int'(IDLE_CYCLES)) begin
                break;
            end
        end
        exp_counts.push_back(byte_count_t'(count));
        exp_partials.push_back(pos != 0);
    endfunction

    function automatic int frame_cycles(input int n_bits);
        return (n_bits - 1) * (SHORT_W + LONG_W) + SHORT_W + IDLE_W;
    endfunction

    // **************************************************
    // Stimulus
    // **************************************************

    task automatic next_cycle(input int n);
        repeat (n) begin
            @(posedge sample_clk);
            #1;
        end
    endtask

    task automatic drive_cell(input int low_w, input int high_w);
        line = 1'b0;
        next_cycle(low_w);
        line = 1'b1;
        next_cycle(high_w);
    endtask

    task automatic queue_bit(input logic b, input logic last);
        if (last) begin
            cells.push_back(SHORT_W);
            cells.push_back(IDLE_W);
        end else if (b) begin
            cells.push_back(SHORT_W);
            cells.push_back(LONG_W);
        end else begin
            cells.push_back(LONG_W);
            cells.push_back(SHORT_W);
        end
    endtask

    task automatic queue_bytes(input int n_bytes, input logic end_frame);
        for (int i = 0; i < n_bytes; i++) begin
            for (int j = 0; j < BITS_PER_BYTE; j++) begin
                queue_bit(frame_data[i][j], end_frame && (i == n_bytes - 1) && (j == 7));
            end
        end
    endtask

    task automatic send_frame(input logic expect_rx);
        if (expect_rx) begin
            decode_cells(cells);
            frames_sent++;
        end
        for (int i = 0; i + 1 < cells.size(); i += 2) begin
            drive_cell(cells[i], cells[i+1]);
        end
        cells.delete();
    endtask

    task automatic wait_for_frame_report();
        int waited;
        waited = 0;
        while ((exp_counts.size() != 0) && (waited < DRAIN_LIMIT)) begin
            next_cycle(1);
            waited++;
        end
        if (exp_counts.size() != 0) begin
            $display("Frame report missing %0d cycles after the frame, at %0t", waited, $time);
            error_count++;
            exp_bytes.delete();
            exp_counts.delete();
            exp_partials.delete();
        end
    endtask

    // **************************************************
    // Output comparison
    // **************************************************

    always @(negedge sample_clk) begin : compare_outputs
        byte_t       exp_b;
        byte_count_t exp_c;
        logic        exp_p;
        if (arst_n) begin
            if (byte_valid) begin
                bytes_seen++;
                if (exp_bytes.size() == 0) begin
                    $display("Unexpected byte %h received at %0t", byte_data, $time);
                    error_count++;
                end else begin
                    exp_b = exp_bytes.pop_front();
                    if (byte_data !== exp_b) begin
                        $display("[ERROR] %0t byte_data got %h expected %h",
                                 $time, byte_data, exp_b);
                        error_count++;
                    end
                end
            end
            if (frame_done) begin
                frames_seen++;
                if (exp_counts.size() == 0) begin
                    $display("Unexpected frame_done at %0t", $time);
                    error_count++;
                end else begin
                    exp_c = exp_counts.pop_front();
                    exp_p = exp_partials.pop_front();
                    if (frame_bytes !== exp_c) begin
                        $display("[ERROR] %0t frame_bytes got %0d expected %0d",
                                 $time, frame_bytes, exp_c);
                        error_count++;
                    end
                    if (frame_partial !== exp_p) begin
                        $display("[ERROR] %0t frame_partial got %b expected %b",
                                 $time, frame_partial, exp_p);
                        error_count++;
                    end
                end
                if (tx_handoff !== frames_sent[0]) begin
                    $display("[ERROR] %0t tx_handoff got %b expected %b",
                             $time, tx_handoff, frames_sent[0]);
                    error_count++;
                end
            end
        end
    end

    always @(posedge sample_clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // **************************************************
    // Test sequence
    // **************************************************

    initial begin : run_tests
        logic [31:0] rnd;
        int          planned;
        int          prop_errors;
        int          frames_before;
        int          bytes_before;
        logic        handoff_before;
        seed        = 32'h00c6_7cc9;
        error_count = 0;
        bytes_seen  = 0;
        frames_seen = 0;
        frames_sent = 0;
        cycle_count = 0;
        arst_n      = 1'b0;
        operation   = 1'b0;
        line        = 1'b1;

        // Random frames up front so the run length is known
        planned = 3 + frame_cycles(8) + frame_cycles(12) + 2 * frame_cycles(8) + 20;
        for (int r = 0; r < RAND_FRAMES; r++) begin
            rnd = $random(seed);
            rand_len[r] = 1 + int'(rnd % 32'd6);
            for (int b = 0; b < MAX_BYTES; b++) begin
                rnd = $random(seed);
                rand_data[r*MAX_BYTES+b] = rnd[7:0];
            end
            rand_data[r*MAX_BYTES+rand_len[r]-1][7] = 1'b1;
            planned += frame_cycles(8 * rand_len[r]);
        end
        foreach (tie_widths[i]) begin
            planned += tie_widths[i];
        end
        cycle_limit = planned * 3 / 2 + 200;

        next_cycle(3);
        arst_n = 1'b1;

        // Idle outputs, then a single byte
        if (byte_valid !== 1'b0) begin
            $display("[ERROR] %0t byte_valid got %b expected 0", $time, byte_valid);
            error_count++;
        end
        if (frame_done !== 1'b0) begin
            $display("[ERROR] %0t frame_done got %b expected 0", $time, frame_done);
            error_count++;
        end
        if (tx_handoff !== 1'b0) begin
            $display("[ERROR] %0t tx_handoff got %b expected 0", $time, tx_handoff);
            error_count++;
        end
        frame_data[0] = 8'hA5;
        queue_bytes(1, 1'b1);
        send_frame(1'b1);
        wait_for_frame_report();

        for (int r = 0; r < RAND_FRAMES; r++) begin
            for (int b = 0; b < rand_len[r]; b++) begin
                frame_data[b] = rand_data[r*MAX_BYTES+b];
            end
            queue_bytes(rand_len[r], 1'b1);
            send_frame(1'b1);
            wait_for_frame_report();
        end

        // Equal widths and a one cycle margin
        foreach (tie_widths[i]) begin
            cells.push_back(tie_widths[i]);
        end
        send_frame(1'b1);
        wait_for_frame_report();

        // Twelve bits leave a partial byte
        frame_data[0] = 8'h3C;
        queue_bytes(1, 1'b0);
        queue_bit(1'b0, 1'b0);
        queue_bit(1'b1, 1'b0);
        queue_bit(1'b0, 1'b0);
        queue_bit(1'b1, 1'b1);
        send_frame(1'b1);
        wait_for_frame_report();

        // Line owned by the transmitter
        operation      = 1'b1;
        handoff_before = tx_handoff;
        frames_before  = frames_seen;
        bytes_before   = bytes_seen;
        next_cycle(2);
        frame_data[0] = 8'hC3;
        queue_bytes(1, 1'b1);
        send_frame(1'b0);
        next_cycle(4);
        if (frames_seen != frames_before || bytes_seen != bytes_before) begin
            $display("Output strobe seen while operation was high, at %0t", $time);
            error_count++;
        end
        if (tx_handoff !== handoff_before) begin
            $display("[ERROR] %0t tx_handoff got %b expected %b",
                     $time, tx_handoff, handoff_before);
            error_count++;
        end
        operation = 1'b0;
        next_cycle(4);
        frame_data[0] = 8'h96;
        queue_bytes(1, 1'b1);
        send_frame(1'b1);
        wait_for_frame_report();

        next_cycle(4);
        if (frames_seen != frames_sent) begin
            $display("[ERROR] %0t frames_seen got %0d expected %0d",
                     $time, frames_seen, frames_sent);
            error_count++;
        end
        if (tx_handoff !== frames_sent[0]) begin
            $display("[ERROR] %0t tx_handoff got %b expected %b",
                     $time, tx_handoff, frames_sent[0]);
            error_count++;
        end
        if (exp_bytes.size() != 0) begin
            $display("%0d expected bytes never arrived", exp_bytes.size());
            error_count++;
        end

        prop_errors = pwl_rx_top_inst.bit_cell_decoder_inst.pwl_rx_props_inst.fail_count;
        $display("Errors: %0d in checks, %0d in assertions; %0d bytes, %0d frames received",
                 error_count, prop_errors, bytes_seen, frames_seen);
        if (error_count == 0 && prop_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/pwl_line_pkg.sv
hdl/pwl_frame_pkg.sv
hdl/line_sync.sv
hdl/pulse_width_timer.sv
hdl/bit_cell_decoder.sv
hdl/byte_assembler.sv
hdl/pwl_rx_top.sv
dv/pwl_rx_props.sv
dv/pwl_rx_tb.sv

// File: hdl/bit_cell_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bit_cell_decoder (
    input  logic sample_clk,
    input  logic arst_n,
    input  logic operation,
    input  logic line_fall,
    input  logic line_rise,
    output logic bit_valid,
    output logic bit_value,
    output logic frame_end,
    output logic tx_handoff
);

    import pwl_line_pkg::*;

    cell_state_t state;
    cell_state_t state_next;

    width_t low_count;
    width_t high_count;
    width_t low_latched;

    logic receiving;
    logic rise_in_low;
    logic idle_reached;
    logic cell_done;
    logic low_clear;
    logic low_en;
    logic high_clear;
    logic high_en;

    // **************************************************
    // Cell events
    // **************************************************

    // Operation high means the line belongs to the transmitter
    assign receiving = !operation;

    assign rise_in_low  = receiving && (state == MEASURE_LOW) && line_rise;
    assign idle_reached = receiving && (state == MEASURE_HIGH) && (high_count >= IDLE_CYCLES);
    // Timeout wins over a fall landing on the same cycle
    assign cell_done    = receiving && (state == MEASURE_HIGH) && line_fall && !idle_reached;

    // Low timer starts on the fall strobe itself so its count equals the low width
    assign low_en    = receiving && ((state == MEASURE_LOW) || line_fall);
    assign low_clear = operation || rise_in_low;

    assign high_en    = receiving && ((state == MEASURE_HIGH) || rise_in_low);
    assign high_clear = operation || cell_done || idle_reached;

    pulse_width_timer low_timer (
        .sample_clk (sample_clk),
        .arst_n     (arst_n),
        .clear      (low_clear),
        .count_en   (low_en),
        .count      (low_count)
    );

    pulse_width_timer high_timer (
        .sample_clk (sample_clk),
        .arst_n     (arst_n),
        .clear      (high_clear),
        .count_en   (high_en),
        .count      (high_count)
    );

    // **************************************************
    // FSM
    // **************************************************

    always_comb begin
        state_next = state;
        if (operation) begin
            state_next = AWAIT_FIRST_FALL;
        end else begin
            case (state)
                AWAIT_FIRST_FALL: begin
                    if (line_fall) begin
                        state_next = MEASURE_LOW;
                    end
                end
                MEASURE_LOW: begin
                    if (line_rise) begin
                        state_next = MEASURE_HIGH;
                    end
                end
                MEASURE_HIGH: begin
                    // A fall with the timeout already starts the next frame
                    if (line_fall) begin
                        state_next = MEASURE_LOW;
                    end else if (idle_reached) begin
                        state_next = AWAIT_FIRST_FALL;
                    end
                end
                default: begin
                    state_next = AWAIT_FIRST_FALL;
                end
            endcase
        end
    end

    always_ff @(posedge sample_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= AWAIT_FIRST_FALL;
            bit_valid  <= 1'b0;
            frame_end  <= 1'b0;
            tx_handoff <= 1'b0;
        end else begin
            state     <= state_next;
            bit_valid <= cell_done || idle_reached;
            frame_end <= idle_reached;
            if (idle_reached) begin
                tx_handoff <= !tx_handoff;
            end
        end
    end

    // Decoded value, ties go to 1
    always_ff @(posedge sample_clk) begin
        if (rise_in_low) begin
            low_latched <= low_count;
        end
        if (cell_done) begin
            bit_value <= !(low_latched > high_count);
        end else if (idle_reached) begin
            bit_value <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/byte_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module byte_assembler (
    input  logic                      sample_clk,
    input  logic                      arst_n,
    input  logic                      bit_valid,
    input  logic                      bit_value,
    input  logic                      frame_end,
    output logic                      byte_valid,
    output pwl_frame_pkg::byte_t       byte_data,
    output logic                      frame_done,
    output pwl_frame_pkg::byte_count_t frame_bytes,
    output logic                      frame_partial
);

    import pwl_frame_pkg::*;

    bit_index_t  bit_pos;
    bit_index_t  pos_next;
    byte_count_t byte_count;
    byte_count_t count_next;
    byte_t       shift_reg;
    byte_t       shift_next;
    logic        byte_complete;

    // LSB first, so new bits enter at the top and move down
    assign shift_next    = {bit_value, shift_reg[BITS_PER_BYTE-1:1]};
    assign byte_complete = bit_valid && (bit_pos == bit_index_t'(BITS_PER_BYTE - 1));

    // Position wraps to zero after the last bit of a byte
    assign pos_next = bit_valid ? bit_pos + 1'b1 : bit_pos;

    assign count_next = (byte_complete && (byte_count != MAX_FRAME_BYTES)) ?
                        byte_count + 1'b1 : byte_count;

    always_ff @(posedge sample_clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_pos    <= '0;
            byte_count <= '0;
            byte_valid <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            byte_valid <= byte_complete;
            frame_done <= frame_end;
            if (frame_end) begin
                bit_pos    <= '0;
                byte_count <= '0;
            end else begin
                bit_pos    <= pos_next;
                byte_count <= count_next;
            end
        end
    end

    // **************************************************
    // Data and frame report
    // **************************************************

    always_ff @(posedge sample_clk) begin
        if (bit_valid) begin
            shift_reg <= shift_next;
        end
        if (byte_complete) begin
            byte_data <= shift_next;
        end
        // Report includes the bit that arrives with frame_end
        if (frame_end) begin
            frame_bytes   <= count_next;
            frame_partial <= (pos_next != '0);
        end
    end

endmodule

`default_nettype wire

// File: hdl/line_sync.sv
`timescale 1ns/1ps
`default_nettype none

module line_sync (
    input  logic sample_clk,
    input  logic arst_n,
    input  logic line,
    output logic line_fall,
    output logic line_rise
);

    logic sync_meta;
    logic sync_line;
    logic sync_prev;

    // Two stage resync plus one history stage
    // All ones out of reset, same as an idle line
    always_ff @(posedge sample_clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_meta <= 1'b1;
            sync_line <= 1'b1;
            sync_prev <= 1'b1;
        end else begin
            sync_meta <= line;
            sync_line <= sync_meta;
            sync_prev <= sync_line;
        end
    end

    // Edge strobes, one cycle each
    assign line_fall = sync_prev & ~sync_line;
    assign line_rise = ~sync_prev & sync_line;

endmodule

`default_nettype wire

// File: hdl/pulse_width_timer.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_width_timer (
    input  logic                 sample_clk,
    input  logic                 arst_n,
    input  logic                 clear,
    input  logic                 count_en,
    output pwl_line_pkg::width_t count
);

    import pwl_line_pkg::*;

    logic saturated;

    // Hold at all ones so a very long phase never wraps to a short one
    assign saturated = (count == {TIMER_W{1'b1}});

    always_ff @(posedge sample_clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (count_en && !saturated) begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pwl_frame_pkg.sv
`default_nettype none

package pwl_frame_pkg;

    // **************************************************
    // Byte packing
    // **************************************************

    localparam int BITS_PER_BYTE = 8;

    // Received byte, first bit on the line lands in bit 0
    typedef logic [BITS_PER_BYTE-1:0] byte_t;

    // Position of the next bit within the byte
    typedef logic [$clog2(BITS_PER_BYTE)-1:0] bit_index_t;

    // **************************************************
    // Frame accounting
    // **************************************************

    // Bytes seen in one frame
    typedef logic [3:0] byte_count_t;

    // Byte count stops here on long frames
    localparam byte_count_t MAX_FRAME_BYTES = 4'd15;

endpackage

`default_nettype wire

// File: hdl/pwl_line_pkg.sv
`default_nettype none

package pwl_line_pkg;

    // **************************************************
    // Phase timing
    // **************************************************

    // Width of one phase counter, saturates at 63
    localparam int TIMER_W = 6;

    // Phase length in sample periods
    typedef logic [TIMER_W-1:0] width_t;

    // High phase of this length ends the frame
    // Must stay below the timer saturation value
    localparam width_t IDLE_CYCLES = 6'd24;

    // **************************************************
    // Bit cell FSM
    // **************************************************

    typedef enum logic [1:0] {
        AWAIT_FIRST_FALL = 2'd0,
        MEASURE_LOW      = 2'd1,
        MEASURE_HIGH     = 2'd2
    } cell_state_t;

endpackage

`default_nettype wire

// File: hdl/pwl_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module pwl_rx_top (
    input  logic                      sample_clk,
    input  logic                      arst_n,
    input  logic                      operation,
    input  logic                      line,
    output logic                      byte_valid,
    output pwl_frame_pkg::byte_t       byte_data,
    output logic                      frame_done,
    output pwl_frame_pkg::byte_count_t frame_bytes,
    output logic                      frame_partial,
    output logic                      tx_handoff
);

    logic line_fall;
    logic line_rise;
    logic bit_valid;
    logic bit_value;
    logic frame_end;

    // Raw wire into the sample clock domain
    line_sync line_sync_inst (
        .sample_clk (sample_clk),
        .arst_n     (arst_n),
        .line       (line),
        .line_fall  (line_fall),
        .line_rise  (line_rise)
    );

    // Phase widths to bits and frame ends
    bit_cell_decoder bit_cell_decoder_inst (
        .sample_clk (sample_clk),
        .arst_n     (arst_n),
        .operation  (operation),
        .line_fall  (line_fall),
        .line_rise  (line_rise),
        .bit_valid  (bit_valid),
        .bit_value  (bit_value),
        .frame_end  (frame_end),
        .tx_handoff (tx_handoff)
    );

    // Bits to bytes and per frame report
    byte_assembler byte_assembler_inst (
        .sample_clk    (sample_clk),
        .arst_n        (arst_n),
        .bit_valid     (bit_valid),
        .bit_value     (bit_value),
        .frame_end     (frame_end),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .frame_done    (frame_done),
        .frame_bytes   (frame_bytes),
        .frame_partial (frame_partial)
    );

endmodule

`default_nettype wire
